/* hdl/xbuf_cfg_regs.sv */
// Configuration registers behind a four-phase req/ack port
// Reset values let the buffer run a full W by H*D pad without any writes
// Address 3 is acknowledged but has no register behind it
`timescale 1ns/10ps
`default_nettype none

module xbuf_cfg_regs #(
  parameter int unsigned H = 4,
  parameter int unsigned W = 4,
  parameter int unsigned D = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             cfg_req_i,
  input  logic [1:0]                       cfg_addr_i,
  input  logic [xbuf_pkg::CFG_W-1:0]       cfg_wdata_i,
  output logic                             cfg_ack_o,
  output xbuf_pkg::xbuf_cfg_t              cfg_o
);
  import xbuf_pkg::*;

  logic req_accept;

  // A request is taken only while ack is low
  assign req_accept = cfg_req_i && !cfg_ack_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin : handshake
    if (!rst_ni) begin
      cfg_ack_o <= 1'b0;
    end else if (req_accept) begin
      cfg_ack_o <= 1'b1;
    end else if (!cfg_req_i) begin
      // Host has released req so close the cycle
      cfg_ack_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : cfg_registers
    if (!rst_ni) begin
      cfg_o.width  <= CFG_W'(W);
      cfg_o.height <= CFG_W'(H * D);
      cfg_o.slots  <= CFG_W'(H * D);
    end else if (req_accept) begin
      case (cfg_addr_i)
        CFG_ADDR_WIDTH: begin
          cfg_o.width <= cfg_wdata_i;
        end
        CFG_ADDR_HEIGHT: begin
          cfg_o.height <= cfg_wdata_i;
        end
        CFG_ADDR_SLOTS: begin
          cfg_o.slots <= cfg_wdata_i;
        end
        default: begin
          // Unmapped address
          cfg_o <= cfg_o;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/xbuf_ctrl.sv */
// Fill and shift control of the X buffer, with the pad and shift memories
// H must be a power of two and D at least 2
// Assumes width <= W, slots a multiple of H and slots <= H*D
`timescale 1ns/10ps
`default_nettype none

module xbuf_ctrl #(
  parameter  int unsigned H  = 4,
  parameter  int unsigned W  = 4,
  parameter  int unsigned D  = 2,
  localparam int unsigned DW = D * H * xbuf_pkg::BITW
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               clear_i,
  input  xbuf_pkg::xbuf_ctrl_t               ctrl_i,
  input  xbuf_pkg::xbuf_cfg_t                cfg_i,
  input  logic [DW-1:0]                      x_data_i,
  output xbuf_pkg::xbuf_flags_t              flags_o,
  output xbuf_pkg::elem_t [W-1:0][H-1:0]     x_tile_o
);
  import xbuf_pkg::*;

  localparam int unsigned DEPTH = H * D;
  localparam int unsigned HW    = $clog2(H);

  typedef enum logic [2:0] {
    PRELOAD,
    FAST_FILL,
    WAIT_FIRST_READ,
    WAIT_SHIFT,
    FILL,
    PAD_EMPTY
  } xbuf_state_e;

  xbuf_state_e              state_q;
  xbuf_state_e              state_d;
  logic [CFG_W-1:0]         load_cnt_q;
  logic [CFG_W-1:0]         pad_rd_cnt_q;
  logic [CFG_W-1:0]         buf_wr_cnt_q;
  logic [CFG_W-1:0]         buf_rd_cnt_q;
  logic                     refilling_q;
  logic                     active;
  logic                     pad_wr_en;
  logic                     pad_rd_en;
  logic                     buf_wr_en;
  logic [$clog2(DEPTH)-1:0] pad_rd_col;
  logic                     last_wr;
  logic                     fast_done;
  logic                     bank0_done;
  elem_t [W-1:0]            pad_col;
  elem_t [W-1:0]            buf_wdata;
  elem_t [H-1:0][W-1:0]     buf_tile;

  assign active        = (state_q != PRELOAD) && (state_q != PAD_EMPTY);
  assign flags_o.full  = (load_cnt_q == cfg_i.width);
  // Pulse on the shift that takes the last slot
  assign flags_o.empty = active && ctrl_i.h_shift && (buf_rd_cnt_q == cfg_i.slots - 1'b1);

  // Beats past a full pad are dropped
  assign pad_wr_en = ctrl_i.load && !flags_o.full;

  // Fast fill writes every cycle, steady fill once per shift
  assign buf_wr_en = !ctrl_i.pad_setup &&
                     ((state_q == FAST_FILL) || (state_q == FILL && ctrl_i.h_shift));

  // Pad output always holds the next column to be written
  assign pad_rd_en  = ctrl_i.pad_setup || buf_wr_en;
  assign pad_rd_col = ctrl_i.pad_setup ? '0 : pad_rd_cnt_q[$clog2(DEPTH)-1:0];

  // Columns at or beyond height become zeros
  assign buf_wdata = (pad_rd_cnt_q > cfg_i.height) ? '0 : pad_col;

  assign last_wr    = buf_wr_en && (buf_wr_cnt_q == cfg_i.slots - 1'b1);
  assign fast_done  = buf_wr_en && (buf_wr_cnt_q == CFG_W'(2 * H - 1));
  assign bank0_done = (buf_rd_cnt_q >= CFG_W'(H)) ||
                      (ctrl_i.h_shift && buf_rd_cnt_q == CFG_W'(H - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin : load_counter
    if (!rst_ni) begin
      load_cnt_q <= '0;
    end else if (clear_i || ctrl_i.rst_w_index) begin
      load_cnt_q <= '0;
    end else if (pad_wr_en) begin
      load_cnt_q <= load_cnt_q + 1'b1;
    end
  end

  // Set while the pad waits for a complete new set of rows
  always_ff @(posedge clk_i or negedge rst_ni) begin : refill_flag
    if (!rst_ni) begin
      refilling_q <= 1'b1;
    end else if (clear_i) begin
      refilling_q <= 1'b1;
    end else if (flags_o.full) begin
      refilling_q <= 1'b0;
    end else if (flags_o.empty) begin
      refilling_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : pad_read_counter
    if (!rst_ni) begin
      pad_rd_cnt_q <= '0;
    end else if (clear_i) begin
      pad_rd_cnt_q <= '0;
    end else if (ctrl_i.pad_setup) begin
      pad_rd_cnt_q <= CFG_W'(1);
    end else if (buf_wr_en) begin
      pad_rd_cnt_q <= pad_rd_cnt_q + 1'b1;
    end
  end

  // Low bits of the write count give {bank, row}
  always_ff @(posedge clk_i or negedge rst_ni) begin : buf_write_counter
    if (!rst_ni) begin
      buf_wr_cnt_q <= '0;
    end else if (clear_i || ctrl_i.pad_setup) begin
      buf_wr_cnt_q <= '0;
    end else if (buf_wr_en) begin
      buf_wr_cnt_q <= buf_wr_cnt_q + 1'b1;
    end
  end

  // Bank toggles every H consumed columns
  always_ff @(posedge clk_i or negedge rst_ni) begin : buf_read_counter
    if (!rst_ni) begin
      buf_rd_cnt_q <= '0;
    end else if (clear_i || ctrl_i.pad_setup || flags_o.empty) begin
      buf_rd_cnt_q <= '0;
    end else if (active && ctrl_i.h_shift) begin
      buf_rd_cnt_q <= buf_rd_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_register
    if (!rst_ni) begin
      state_q <= PRELOAD;
    end else if (clear_i) begin
      state_q <= PRELOAD;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin : next_state
    state_d = state_q;
    if (ctrl_i.pad_setup) begin
      state_d = FAST_FILL;
    end else begin
      case (state_q)
        FAST_FILL: begin
          if (flags_o.empty) begin
            state_d = PAD_EMPTY;
          end else if (last_wr) begin
            state_d = WAIT_SHIFT;
          end else if (fast_done) begin
            // Bank 0 may already be used up if shifting started early
            state_d = bank0_done ? FILL : WAIT_FIRST_READ;
          end
        end
        WAIT_FIRST_READ: begin
          if (ctrl_i.h_shift && buf_rd_cnt_q == CFG_W'(H - 1)) begin
            state_d = FILL;
          end
        end
        FILL: begin
          if (flags_o.empty) begin
            state_d = PAD_EMPTY;
          end else if (last_wr) begin
            state_d = WAIT_SHIFT;
          end
        end
        WAIT_SHIFT: begin
          if (flags_o.empty) begin
            state_d = PAD_EMPTY;
          end
        end
        PAD_EMPTY: begin
          if (!refilling_q) begin
            state_d = PRELOAD;
          end
        end
        default: begin
          state_d = PRELOAD;
        end
      endcase
    end
  end

  xbuf_pad_mem #(
    .W     ( W     ),
    .DEPTH ( DEPTH )
  ) i_pad_mem (
    .clk_i       ( clk_i                        ),
    .rst_ni      ( rst_ni                       ),
    .clear_i     ( clear_i                      ),
    .write_en_i  ( pad_wr_en                    ),
    .write_row_i ( load_cnt_q[$clog2(W)-1:0]    ),
    .wdata_i     ( x_data_i                     ),
    .read_en_i   ( pad_rd_en                    ),
    .read_col_i  ( pad_rd_col                   ),
    .rdata_o     ( pad_col                      )
  );

  xbuf_shift_mem #(
    .W ( W ),
    .H ( H )
  ) i_shift_mem (
    .clk_i        ( clk_i              ),
    .rst_ni       ( rst_ni             ),
    .clear_i      ( clear_i            ),
    .write_en_i   ( buf_wr_en          ),
    .write_addr_i ( buf_wr_cnt_q[HW:0] ),
    .wdata_i      ( buf_wdata          ),
    .read_bank_i  ( buf_rd_cnt_q[HW]   ),
    .rdata_o      ( buf_tile           )
  );

  // Rows of the bank are columns of the tile
  for (genvar w = 0; w < W; w++) begin : gen_tile_w
    for (genvar h = 0; h < H; h++) begin : gen_tile_h
      assign x_tile_o[w][h] = buf_tile[h][w];
    end
  end

endmodule

`default_nettype wire

/* hdl/xbuf_pad_mem.sv */
// Pad storage of W rows, each one streamer beat of DEPTH elements
// A whole row is written per load, one column of all rows is read per cycle
// Read data is registered and holds while no read is requested
`timescale 1ns/10ps
`default_nettype none

module xbuf_pad_mem #(
  parameter int unsigned W     = 4,
  parameter int unsigned DEPTH = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clear_i,
  input  logic                                write_en_i,
  input  logic [$clog2(W)-1:0]                write_row_i,
  input  xbuf_pkg::elem_t [DEPTH-1:0]         wdata_i,
  input  logic                                read_en_i,
  input  logic [$clog2(DEPTH)-1:0]            read_col_i,
  output xbuf_pkg::elem_t [W-1:0]             rdata_o
);
  import xbuf_pkg::*;

  elem_t [DEPTH-1:0] mem_q [W];

  always_ff @(posedge clk_i) begin : pad_storage
    if (clear_i) begin
      for (int unsigned r = 0; r < W; r++) begin
        mem_q[r] <= '0;
      end
    end else if (write_en_i) begin
      mem_q[write_row_i] <= wdata_i;
    end
  end

  // Column read across every row
  always_ff @(posedge clk_i or negedge rst_ni) begin : column_read
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (clear_i) begin
      rdata_o <= '0;
    end else if (read_en_i) begin
      for (int unsigned r = 0; r < W; r++) begin
        rdata_o[r] <= mem_q[r][read_col_i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/xbuf_pkg.sv */
// Shared types for the X-operand staging buffer
// Elements are fixed 16-bit words with no format selection
// Configuration values are 8-bit counts, so H*D and W must stay below 256
`default_nettype none

package xbuf_pkg;

  localparam int unsigned BITW  = 16;
  localparam int unsigned CFG_W = 8;

  // One half-precision element
  typedef logic [BITW-1:0] elem_t;

  // Per-cycle commands from the scheduler
  typedef struct packed {
    logic load;
    logic pad_setup;
    logic h_shift;
    logic rst_w_index;
  } xbuf_ctrl_t;

  // Status back to the scheduler
  typedef struct packed {
    logic full;
    logic empty;
  } xbuf_flags_t;

  // Software view of the buffer geometry
  typedef struct packed {
    logic [CFG_W-1:0] width;
    logic [CFG_W-1:0] height;
    logic [CFG_W-1:0] slots;
  } xbuf_cfg_t;

  // Register map of the configuration port
  localparam logic [1:0] CFG_ADDR_WIDTH  = 2'd0;
  localparam logic [1:0] CFG_ADDR_HEIGHT = 2'd1;
  localparam logic [1:0] CFG_ADDR_SLOTS  = 2'd2;

endpackage

`default_nettype wire

/* hdl/xbuf_shift_mem.sv */
// Double-banked column buffer of H rows per bank
// The whole read bank is shown combinationally, so the tile holds
// for as long as the read bank does not change
`timescale 1ns/10ps
`default_nettype none

module xbuf_shift_mem #(
  parameter int unsigned W = 4,
  parameter int unsigned H = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   clear_i,
  input  logic                                   write_en_i,
  input  logic [$clog2(H):0]                     write_addr_i,
  input  xbuf_pkg::elem_t [W-1:0]                wdata_i,
  input  logic                                   read_bank_i,
  output xbuf_pkg::elem_t [H-1:0][W-1:0]         rdata_o
);
  import xbuf_pkg::*;

  localparam int unsigned RW = $clog2(H);

  elem_t [H-1:0][W-1:0] bank_q [2];
  logic                 wr_bank;
  logic [RW-1:0]        wr_row;

  // Top address bit selects the bank
  assign wr_bank = write_addr_i[RW];
  assign wr_row  = write_addr_i[RW-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin : bank_storage
    if (!rst_ni) begin
      bank_q[0] <= '0;
      bank_q[1] <= '0;
    end else if (clear_i) begin
      bank_q[0] <= '0;
      bank_q[1] <= '0;
    end else if (write_en_i) begin
      bank_q[wr_bank][wr_row] <= wdata_i;
    end
  end

  assign rdata_o = bank_q[read_bank_i];

endmodule

`default_nettype wire

/* hdl/xbuf_top.sv */
// X-operand staging subsystem: configuration block plus buffer
// H, W and D are set here, the beat width is D*H 16-bit elements
`timescale 1ns/10ps
`default_nettype none

module xbuf_top #(
  parameter  int unsigned H  = 4,
  parameter  int unsigned W  = 4,
  parameter  int unsigned D  = 2,
  localparam int unsigned DW = D * H * xbuf_pkg::BITW
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  logic                             cfg_req_i,
  input  logic [1:0]                       cfg_addr_i,
  input  logic [xbuf_pkg::CFG_W-1:0]       cfg_wdata_i,
  output logic                             cfg_ack_o,
  input  xbuf_pkg::xbuf_ctrl_t             ctrl_i,
  input  logic [DW-1:0]                    x_data_i,
  output xbuf_pkg::xbuf_flags_t            flags_o,
  output xbuf_pkg::elem_t [W-1:0][H-1:0]   x_tile_o
);
  import xbuf_pkg::*;

  xbuf_cfg_t cfg;

  xbuf_cfg_regs #(
    .H ( H ),
    .W ( W ),
    .D ( D )
  ) i_cfg_regs (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_ack_o   ( cfg_ack_o   ),
    .cfg_o       ( cfg         )
  );

  xbuf_ctrl #(
    .H ( H ),
    .W ( W ),
    .D ( D )
  ) i_ctrl (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .clear_i  ( clear_i  ),
    .ctrl_i   ( ctrl_i   ),
    .cfg_i    ( cfg      ),
    .x_data_i ( x_data_i ),
    .flags_o  ( flags_o  ),
    .x_tile_o ( x_tile_o )
  );

endmodule

`default_nettype wire

/* list.f */
hdl/xbuf_pkg.sv
hdl/xbuf_cfg_regs.sv
hdl/xbuf_pad_mem.sv
hdl/xbuf_shift_mem.sv
hdl/xbuf_ctrl.sv
hdl/xbuf_top.sv
testbench/tb_xbuf_top.sv

/* testbench/tb_xbuf_top.sv */
// Directed testbench for the X-operand staging subsystem with H=4, W=4, D=2
// Width stays at W so that every pad row holds defined data
`timescale 1ns/10ps
`default_nettype none

module tb_xbuf_top;
  import xbuf_pkg::*;

  localparam int unsigned H       = 4;
  localparam int unsigned W       = 4;
  localparam int unsigned D       = 2;
  localparam int unsigned DEPTH   = H * D;
  localparam int unsigned DW      = DEPTH * BITW;
  localparam int unsigned TIMEOUT = 50;

  logic                 clk;
  logic                 rst_n;
  logic                 clear;
  logic                 cfg_req;
  logic [1:0]           cfg_addr;
  logic [CFG_W-1:0]     cfg_wdata;
  logic                 cfg_ack;
  xbuf_ctrl_t           ctrl;
  logic [DW-1:0]        x_data;
  xbuf_flags_t          flags;
  elem_t [W-1:0][H-1:0] x_tile;

  // Reference copy of the pad and of the written configuration
  elem_t       pad_model [W][DEPTH];
  xbuf_cfg_t   cfg_model;
  integer      seed = 32'hbb8c_e993;
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned test_errors = 0;

  xbuf_top #(
    .H ( H ),
    .W ( W ),
    .D ( D )
  ) i_xbuf_top (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .clear_i     ( clear     ),
    .cfg_req_i   ( cfg_req   ),
    .cfg_addr_i  ( cfg_addr  ),
    .cfg_wdata_i ( cfg_wdata ),
    .cfg_ack_o   ( cfg_ack   ),
    .ctrl_i      ( ctrl      ),
    .x_data_i    ( x_data    ),
    .flags_o     ( flags     ),
    .x_tile_o    ( x_tile    )
  );

  always #5 clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_val);
    checks++;
    assert (got === exp_val) else begin
      $display("ERR %s got %h expected %h", name, got, exp_val);
      errors++;
    end
  endtask

  // Columns at or beyond height are expected as zero
  task automatic compare_tile(input int unsigned group, input bit zero_all);
    int unsigned col;
    elem_t       exp_elem;
    for (int unsigned w = 0; w < W; w++) begin
      for (int unsigned h = 0; h < H; h++) begin
        col = group * H + h;
        exp_elem = (zero_all || col >= cfg_model.height) ? '0 : pad_model[w][col];
        compare_value($sformatf("x_tile_o[%0d][%0d]", w, h), x_tile[w][h], exp_elem);
      end
    end
  endtask

  // Configuration fields against the values written so far
  task automatic compare_cfg();
    compare_value("cfg.width", i_xbuf_top.cfg.width, cfg_model.width);
    compare_value("cfg.height", i_xbuf_top.cfg.height, cfg_model.height);
    compare_value("cfg.slots", i_xbuf_top.cfg.slots, cfg_model.slots);
  endtask

  task automatic wait_ack(input logic level);
    int unsigned n;
    n = 0;
    while (cfg_ack !== level && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (cfg_ack === level) else begin
      $display("cfg_ack_o did not go %s within %0d cycles", level ? "high" : "low", TIMEOUT);
      errors++;
    end
  endtask

  task automatic write_cfg(input logic [1:0] addr, input logic [CFG_W-1:0] data);
    @(posedge clk);
    cfg_addr  <= addr;
    cfg_wdata <= data;
    cfg_req   <= 1'b1;
    wait_ack(1'b1);
    @(posedge clk);
    cfg_req <= 1'b0;
    wait_ack(1'b0);
    if (addr == CFG_ADDR_WIDTH) begin
      cfg_model.width = data;
    end else if (addr == CFG_ADDR_HEIGHT) begin
      cfg_model.height = data;
    end else if (addr == CFG_ADDR_SLOTS) begin
      cfg_model.slots = data;
    end
  endtask

  task automatic send_beat(input int unsigned row);
    logic [DW-1:0] beat;
    elem_t         elem;
    for (int unsigned c = 0; c < DEPTH; c++) begin
      elem = elem_t'($random(seed));
      beat[c*BITW +: BITW] = elem;
      pad_model[row][c] = elem;
    end
    @(posedge clk);
    x_data    <= beat;
    ctrl.load <= 1'b1;
    @(posedge clk);
    ctrl.load <= 1'b0;
  endtask

  // Full must stay low until the width-th beat is stored
  task automatic load_pad();
    @(negedge clk);
    compare_value("flags_o.full", flags.full, 1'b0);
    for (int unsigned r = 0; r < cfg_model.width; r++) begin
      send_beat(r);
      @(negedge clk);
      compare_value("flags_o.full", flags.full, (r + 1 == cfg_model.width));
    end
  endtask

  task automatic reset_windex();
    @(posedge clk);
    ctrl.rst_w_index <= 1'b1;
    @(posedge clk);
    ctrl.rst_w_index <= 1'b0;
    @(negedge clk);
    compare_value("flags_o.full", flags.full, 1'b0);
  endtask

  task automatic setup_pad();
    @(posedge clk);
    ctrl.pad_setup <= 1'b1;
    @(posedge clk);
    ctrl.pad_setup <= 1'b0;
  endtask

  // Bank 0 is complete H cycles after the setup edge
  task automatic check_first_tile();
    setup_pad();
    repeat (H + 1) @(posedge clk);
    @(negedge clk);
    compare_tile(0, 1'b0);
  endtask

  task automatic issue_shift(input bit last);
    @(posedge clk);
    ctrl.h_shift <= 1'b1;
    @(negedge clk);
    compare_value("flags_o.empty", flags.empty, last);
    @(posedge clk);
    ctrl.h_shift <= 1'b0;
  endtask

  // Tile holds during gaps and moves to the next group after H shifts
  task automatic shift_groups();
    int unsigned groups;
    int unsigned gap;
    groups = cfg_model.slots / H;
    for (int unsigned k = 0; k < groups; k++) begin
      for (int unsigned j = 0; j < H; j++) begin
        issue_shift(k == groups - 1 && j == H - 1);
        gap = 1 + ($unsigned($random(seed)) % 3);
        repeat (gap) @(posedge clk);
        @(negedge clk);
        compare_value("flags_o.empty", flags.empty, 1'b0);
        if (j < H - 1) begin
          compare_tile(k, 1'b0);
        end else if (k + 1 < groups) begin
          compare_tile(k + 1, 1'b0);
        end
      end
    end
  endtask

  task automatic finish_test(input int unsigned num, input string name);
    $display("test %0d %s finished with %0d errors", num, name, errors - test_errors);
    test_errors = errors;
  endtask

  initial begin : stimulus
    clk       = 1'b0;
    rst_n     = 1'b0;
    clear     = 1'b0;
    cfg_req   = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    ctrl      = '0;
    x_data    = '0;
    cfg_model.width  = CFG_W'(W);
    cfg_model.height = CFG_W'(DEPTH);
    cfg_model.slots  = CFG_W'(DEPTH);
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Values away from the reset geometry first, then the geometry used below
    write_cfg(CFG_ADDR_WIDTH, CFG_W'(W - 1));
    write_cfg(CFG_ADDR_HEIGHT, CFG_W'(DEPTH - 1));
    write_cfg(CFG_ADDR_SLOTS, CFG_W'(H));
    compare_cfg();
    write_cfg(CFG_ADDR_WIDTH, CFG_W'(W));
    write_cfg(CFG_ADDR_HEIGHT, CFG_W'(DEPTH));
    write_cfg(CFG_ADDR_SLOTS, CFG_W'(DEPTH));
    // Unmapped address only completes the handshake
    write_cfg(2'd3, 8'h5a);
    compare_cfg();
    finish_test(1, "config handshake");

    load_pad();
    reset_windex();
    finish_test(2, "load and full");

    check_first_tile();
    finish_test(3, "first tile");

    shift_groups();
    finish_test(4, "shift through groups");

    write_cfg(CFG_ADDR_HEIGHT, CFG_W'(DEPTH - 2));
    load_pad();
    reset_windex();
    check_first_tile();
    shift_groups();
    finish_test(5, "height padding");

    load_pad();
    setup_pad();
    repeat (2) @(posedge clk);
    issue_shift(1'b0);
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    @(negedge clk);
    compare_value("flags_o.full", flags.full, 1'b0);
    compare_value("flags_o.empty", flags.empty, 1'b0);
    compare_tile(0, 1'b1);
    compare_cfg();
    finish_test(6, "clear");

    $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Upper bound on the whole run
  initial begin : watchdog
    #200_000;
    $display("simulation did not finish within the time limit");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire
